//--- bench/rv_core_assertions.sv
module rv_core_assertions (
  input logic          clk,
  input logic          rst,
  input rv_pkg::word_t pc,
  input rv_pkg::word_t dmem_addr,
  input logic [3:0]    store_we,
  input logic          halt
);
  timeunit 1ns;
  timeprecision 1ps;

  pc_aligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
    else $error("pc not word aligned");

  addr_aligned: assert property (@(posedge clk) disable iff (rst) dmem_addr[1:0] == 2'b00)
    else $error("dmem_addr not word aligned");

  // byte, halfword or full word lanes only
  we_legal: assert property (@(posedge clk)
    store_we inside {4'h0, 4'h1, 4'h2, 4'h4, 4'h8, 4'h3, 4'hc, 4'hf})
    else $error("store_we has an illegal lane pattern");

  no_store_halted: assert property (@(posedge clk) halt |-> store_we == 4'h0)
    else $error("store_we active while halted");

  no_store_reset: assert property (@(posedge clk) rst |-> store_we == 4'h0)
    else $error("store_we active during reset");

endmodule

bind rv_core rv_core_assertions i_chk (
  .clk(clk), .rst(rst), .pc(pc), .dmem_addr(dmem_addr), .store_we(store_we), .halt(halt)
);

//--- bench/rv_core_tb.sv
module rv_core_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import rv_pkg::*;

  localparam int PERIOD = 40;

  logic       clk;
  logic       rst;
  word_t      insn;
  word_t      load_data;
  word_t      pc;
  word_t      dmem_addr;
  word_t      store_data;
  logic [3:0] store_we;
  logic       halt;

  // program table with one entry per instruction
  string      t_name[$];
  word_t      t_insn[$];
  word_t      t_load[$];
  word_t      t_pc[$];
  bit         t_chk_addr[$];
  word_t      t_addr[$];
  word_t      t_data[$];
  logic [3:0] t_we[$];
  logic       t_halt[$];

  int errors = 0;
  int row_errors;
  int cycles = 0;
  int max_cycles = 0;

  rv_core #(.RESET_PC(32'h0)) i_dut (
    .clk(clk), .rst(rst), .pc(pc), .insn(insn), .dmem_addr(dmem_addr),
    .load_data(load_data), .store_data(store_data), .store_we(store_we), .halt(halt)
  );

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (max_cycles > 0 && cycles > max_cycles) begin
      $display("run stopped: cycle limit %0d reached", max_cycles);
      $display("Errors found");
      $finish;
    end
  end

  // instruction encoders for the RV32I formats
  function automatic word_t enc_i(int imm, int rs1, int f3, int rd, opcode_t op);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
  endfunction

  function automatic word_t enc_s(int imm, int rs2, int rs1, int f3);
    return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], OP_STORE};
  endfunction

  function automatic word_t enc_b(int off, int rs1, int rs2, int f3);
    return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], OP_BRANCH};
  endfunction

  function automatic word_t enc_r(int f7, int rs2, int rs1, int f3, int rd);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], OP_REG_REG};
  endfunction

  function automatic word_t enc_u(int imm, int rd, opcode_t op);
    return {imm[19:0], rd[4:0], op};
  endfunction

  task automatic add_row(string name, word_t ins, word_t ld, word_t exp_pc, bit chk_addr,
                         word_t addr, word_t data, logic [3:0] we, logic hlt);
    t_name.push_back(name);
    t_insn.push_back(ins);
    t_load.push_back(ld);
    t_pc.push_back(exp_pc);
    t_chk_addr.push_back(chk_addr);
    t_addr.push_back(addr);
    t_data.push_back(data);
    t_we.push_back(we);
    t_halt.push_back(hlt);
  endtask

  task automatic check_word(string name, string what, word_t exp, word_t act);
    assert (act === exp) else begin
      $display("** Error %s %s: expected %h, actual %h", name, what, exp, act);
      errors++;
      row_errors++;
    end
  endtask

  task automatic build_table();
    word_t lw_val;
    lw_val = 32'h80ff7f01;  // lanes 01 7f ff 80 from low to high
    add_row("lui", enc_u('h12345, 1, OP_LUI), 0, 0, 0, 0, 0, 4'h0, 1'b0);
    add_row("addi", enc_i('h678, 1, 0, 1, OP_REG_IMM), 0, 4, 0, 0, 0, 4'h0, 1'b0);
    add_row("auipc", enc_u('h1, 2, OP_AUIPC), 0, 8, 0, 0, 0, 4'h0, 1'b0);
    add_row("addi_neg", enc_i(-8, 0, 0, 3, OP_REG_IMM), 0, 12, 0, 0, 0, 4'h0, 1'b0);
    add_row("sw_lui", enc_s('h100, 1, 0, 2), 0, 16, 1, 'h100, 'h12345678, 4'hf, 1'b0);
    add_row("sw_auipc", enc_s(4, 2, 3, 2), 0, 20, 1, 'hfffffffc, 'h1008, 4'hf, 1'b0);
    add_row("sub", enc_r('h20, 1, 3, 0, 4), 0, 24, 0, 0, 0, 4'h0, 1'b0);
    add_row("sw_sub", enc_s(0, 4, 0, 2), 0, 28, 1, 0, 'hedcba980, 4'hf, 1'b0);
    add_row("srai", enc_i('h404, 4, 5, 5, OP_REG_IMM), 0, 32, 0, 0, 0, 4'h0, 1'b0);
    add_row("sw_srai", enc_s(8, 5, 0, 2), 0, 36, 1, 8, 'hfedcba98, 4'hf, 1'b0);
    add_row("slt", enc_r(0, 1, 3, 2, 6), 0, 40, 0, 0, 0, 4'h0, 1'b0);
    add_row("sltu", enc_r(0, 1, 3, 3, 7), 0, 44, 0, 0, 0, 4'h0, 1'b0);
    add_row("sw_slt", enc_s(12, 6, 0, 2), 0, 48, 1, 12, 1, 4'hf, 1'b0);
    add_row("sw_sltu", enc_s(16, 7, 0, 2), 0, 52, 1, 16, 0, 4'hf, 1'b0);
    add_row("addi_x0", enc_i(5, 0, 0, 0, OP_REG_IMM), 0, 56, 0, 0, 0, 4'h0, 1'b0);
    add_row("sw_x0", enc_s(20, 0, 0, 2), 0, 60, 1, 20, 0, 4'hf, 1'b0);
    // x3 = -8, x6 = 1, x7 = 0
    add_row("beq_nt", enc_b(8, 6, 7, 0), 0, 64, 0, 0, 0, 4'h0, 1'b0);
    add_row("beq_t", enc_b(8, 0, 7, 0), 0, 68, 0, 0, 0, 4'h0, 1'b0);
    add_row("bne_t", enc_b(8, 6, 7, 1), 0, 76, 0, 0, 0, 4'h0, 1'b0);
    add_row("bne_nt", enc_b(8, 0, 7, 1), 0, 84, 0, 0, 0, 4'h0, 1'b0);
    add_row("blt_t", enc_b(8, 3, 6, 4), 0, 88, 0, 0, 0, 4'h0, 1'b0);
    add_row("blt_nt", enc_b(8, 6, 3, 4), 0, 96, 0, 0, 0, 4'h0, 1'b0);
    add_row("bge_t", enc_b(8, 6, 3, 5), 0, 100, 0, 0, 0, 4'h0, 1'b0);
    add_row("bge_nt", enc_b(8, 3, 6, 5), 0, 108, 0, 0, 0, 4'h0, 1'b0);
    add_row("bltu_t", enc_b(8, 6, 3, 6), 0, 112, 0, 0, 0, 4'h0, 1'b0);
    add_row("bltu_nt", enc_b(8, 3, 6, 6), 0, 120, 0, 0, 0, 4'h0, 1'b0);
    add_row("bgeu_t", enc_b(8, 3, 6, 7), 0, 124, 0, 0, 0, 4'h0, 1'b0);
    add_row("bgeu_nt", enc_b(8, 7, 6, 7), 0, 132, 0, 0, 0, 4'h0, 1'b0);
    add_row("lb_l3", enc_i('h103, 0, 0, 8, OP_LOAD), lw_val, 136, 1, 'h100, 0, 4'h0, 1'b0);
    add_row("sw_lb_l3", enc_s(0, 8, 0, 2), 0, 140, 1, 0, 'hffffff80, 4'hf, 1'b0);
    add_row("lbu_l2", enc_i('h102, 0, 4, 9, OP_LOAD), lw_val, 144, 1, 'h100, 0, 4'h0, 1'b0);
    add_row("sw_lbu_l2", enc_s(0, 9, 0, 2), 0, 148, 1, 0, 'h000000ff, 4'hf, 1'b0);
    add_row("lh_hi", enc_i('h102, 0, 1, 10, OP_LOAD), lw_val, 152, 1, 'h100, 0, 4'h0, 1'b0);
    add_row("sw_lh_hi", enc_s(0, 10, 0, 2), 0, 156, 1, 0, 'hffff80ff, 4'hf, 1'b0);
    add_row("lhu_lo", enc_i('h100, 0, 5, 11, OP_LOAD), lw_val, 160, 1, 'h100, 0, 4'h0, 1'b0);
    add_row("sw_lhu_lo", enc_s(0, 11, 0, 2), 0, 164, 1, 0, 'h00007f01, 4'hf, 1'b0);
    add_row("lb_l1", enc_i('h101, 0, 0, 12, OP_LOAD), lw_val, 168, 1, 'h100, 0, 4'h0, 1'b0);
    add_row("sw_lb_l1", enc_s(0, 12, 0, 2), 0, 172, 1, 0, 'h0000007f, 4'hf, 1'b0);
    add_row("lw", enc_i('h100, 0, 2, 13, OP_LOAD), lw_val, 176, 1, 'h100, 0, 4'h0, 1'b0);
    add_row("sw_lw", enc_s(0, 13, 0, 2), 0, 180, 1, 0, 'h80ff7f01, 4'hf, 1'b0);
    add_row("sb_l1", enc_s('h21, 1, 0, 0), 0, 184, 1, 'h20, 'h78787878, 4'b0010, 1'b0);
    add_row("sb_l3", enc_s('h23, 1, 0, 0), 0, 188, 1, 'h20, 'h78787878, 4'b1000, 1'b0);
    add_row("sh_hi", enc_s('h22, 1, 0, 1), 0, 192, 1, 'h20, 'h56785678, 4'b1100, 1'b0);
    add_row("sh_lo", enc_s('h20, 1, 0, 1), 0, 196, 1, 'h20, 'h56785678, 4'b0011, 1'b0);
    add_row("ecall", 32'h00000073, 0, 200, 0, 0, 0, 4'h0, 1'b1);
    add_row("ecall_hold1", 32'h00000073, 0, 200, 0, 0, 0, 4'h0, 1'b1);
    add_row("ecall_hold2", 32'h00000073, 0, 200, 0, 0, 0, 4'h0, 1'b1);
  endtask

  initial begin
    rst = 1'b1;
    insn = enc_s(0, 1, 0, 2);  // sw held in reset, store_we must stay low
    load_data = '0;
    build_table();
    max_cycles = t_name.size() + 3 + 10;
    repeat (3) @(posedge clk);
    foreach (t_name[i]) begin
      #1;
      rst = 1'b0;
      insn = t_insn[i];
      load_data = t_load[i];
      #(PERIOD - 3);  // just before the next rising edge
      row_errors = 0;
      check_word(t_name[i], "pc", t_pc[i], pc);
      check_word(t_name[i], "halt", {31'd0, t_halt[i]}, {31'd0, halt});
      check_word(t_name[i], "store_we", {28'd0, t_we[i]}, {28'd0, store_we});
      if (t_chk_addr[i]) check_word(t_name[i], "dmem_addr", t_addr[i], dmem_addr);
      if (t_we[i] != 4'h0) check_word(t_name[i], "store_data", t_data[i], store_data);
      if (row_errors == 0) $display("%s: ok", t_name[i]);
      else $display("%s: failed", t_name[i]);
      @(posedge clk);
    end
    $display("tests %0d, failed checks %0d", t_name.size(), errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

//--- run.sh
#!/usr/bin/env bash
set -eo pipefail
cd "$(dirname "$0")"

verilator --binary --assert --top-module rv_core_tb -f sim.f -o vsim_rv_core
./obj_dir/vsim_rv_core | tee sim.log

if grep -q "Errors found" sim.log; then
  echo "simulation failed"
  exit 1
fi
if ! grep -q "No errors" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi
echo "simulation passed"

//--- sim.f
source/rv_pkg.sv
source/insn_decode.sv
source/reg_file.sv
source/alu.sv
source/pc_unit.sv
source/lsu.sv
source/rv_core.sv
bench/rv_core_assertions.sv
bench/rv_core_tb.sv

//--- source/alu.sv
module alu (
  input  rv_pkg::alu_op_t op,
  input  rv_pkg::word_t   a,
  input  rv_pkg::word_t   b,
  output rv_pkg::word_t   result
);
  import rv_pkg::*;

  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;

  assign shamt       = b[4:0];
  assign lt_signed   = $signed(a) < $signed(b);
  assign lt_unsigned = a < b;

  always_comb begin
    case (op)
      ALU_ADD:  result = a + b;
      ALU_SUB:  result = a - b;
      ALU_SLL:  result = a << shamt;
      ALU_SLT:  result = {31'd0, lt_signed};
      ALU_SLTU: result = {31'd0, lt_unsigned};
      ALU_XOR:  result = a ^ b;
      ALU_SRL:  result = a >> shamt;
      ALU_SRA:  result = $signed(a) >>> shamt;  // sign fill
      ALU_OR:   result = a | b;
      ALU_AND:  result = a & b;
      default:  result = '0;
    endcase
  end

endmodule

//--- source/insn_decode.sv
module insn_decode (
  input  rv_pkg::word_t    insn,
  output rv_pkg::reg_idx_t rs1,
  output rv_pkg::reg_idx_t rs2,
  output rv_pkg::reg_idx_t rd,
  output rv_pkg::word_t    imm,
  output rv_pkg::alu_op_t  alu_op,
  output logic             alu_src_imm,
  output logic             reg_we,
  output logic             is_load,
  output logic             is_store,
  output logic             is_branch,
  output logic             is_lui,
  output logic             is_auipc,
  output logic             is_ecall,
  output logic [2:0]       funct3
);
  import rv_pkg::*;

  opcode_t    opcode;
  logic [6:0] funct7;
  logic       is_reg_imm;
  logic       is_reg_reg;
  logic       width_ok;   // legal load width
  logic       alt_ok;     // funct7 legal for reg-reg / shifts

  assign {funct7, rs2, rs1, funct3, rd, opcode} = insn;

  always_comb begin
    case (opcode)
      OP_STORE:          imm = {{20{insn[31]}}, insn[31:25], insn[11:7]};
      OP_BRANCH:         imm = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
      OP_LUI, OP_AUIPC:  imm = {insn[31:12], 12'h000};
      default:           imm = {{20{insn[31]}}, insn[31:20]}; // I form
    endcase
  end

  always_comb begin
    width_ok = funct3 inside {FUNCT3_BYTE, FUNCT3_HALF, FUNCT3_WORD,
                              FUNCT3_BYTE_U, FUNCT3_HALF_U};
    // funct7 bit 5 only selects sub / sra; shifts-immediate check funct7 too
    alt_ok = (funct7 == 7'd0) || (funct7 == 7'b0100000 && (funct3 == 3'b101
             || (opcode == OP_REG_REG && funct3 == 3'b000)));
  end

  assign is_reg_imm  = (opcode == OP_REG_IMM) && (alt_ok || !(funct3 inside {3'b001, 3'b101}));
  assign is_reg_reg  = (opcode == OP_REG_REG) && alt_ok;
  assign is_load     = (opcode == OP_LOAD) && width_ok;
  assign is_store    = (opcode == OP_STORE) && funct3 inside {FUNCT3_BYTE, FUNCT3_HALF, FUNCT3_WORD};
  assign is_branch   = (opcode == OP_BRANCH);
  assign is_lui      = (opcode == OP_LUI);
  assign is_auipc    = (opcode == OP_AUIPC);
  assign is_ecall    = (opcode == OP_ENVIRON) && (insn[31:7] == 25'd0);
  assign alu_src_imm = (opcode != OP_REG_REG);  // rs2 only for reg-reg
  assign reg_we      = is_reg_imm || is_reg_reg || is_load || is_lui || is_auipc;

  always_comb begin
    alu_op = ALU_ADD;  // loads, stores: address add
    if (opcode == OP_REG_IMM || opcode == OP_REG_REG) begin
      case (funct3)
        3'b000:  alu_op = (opcode == OP_REG_REG && funct7[5]) ? ALU_SUB : ALU_ADD;
        3'b001:  alu_op = ALU_SLL;
        3'b010:  alu_op = ALU_SLT;
        3'b011:  alu_op = ALU_SLTU;
        3'b100:  alu_op = ALU_XOR;
        3'b101:  alu_op = funct7[5] ? ALU_SRA : ALU_SRL;
        3'b110:  alu_op = ALU_OR;
        default: alu_op = ALU_AND;
      endcase
    end
  end

endmodule

//--- source/lsu.sv
module lsu (
  input  logic          is_load,
  input  logic          is_store,
  input  logic          rst,
  input  logic [2:0]    funct3,
  input  rv_pkg::word_t addr,
  input  rv_pkg::word_t rs2_data,
  input  rv_pkg::word_t load_data,
  output rv_pkg::word_t dmem_addr,
  output rv_pkg::word_t store_data,
  output rv_pkg::word_t load_result,
  output logic [3:0]    store_we
);
  import rv_pkg::*;

  mem_word_u  ld_view;
  mem_word_u  st_view;
  logic [7:0] ld_byte;
  logic [15:0] ld_half;
  logic [3:0] lane_en;

  assign dmem_addr = {addr[31:2], 2'b00};  // memory sees words only

  // load lane pick
  always_comb begin
    ld_view.word = load_data;
    ld_byte      = ld_view.bytes[addr[1:0]];
    ld_half      = ld_view.halves[addr[1]];
    case (funct3)
      FUNCT3_BYTE:   load_result = {{24{ld_byte[7]}}, ld_byte};
      FUNCT3_HALF:   load_result = {{16{ld_half[15]}}, ld_half};
      FUNCT3_BYTE_U: load_result = {24'd0, ld_byte};
      FUNCT3_HALF_U: load_result = {16'd0, ld_half};
      default:       load_result = ld_view.word;
    endcase
    if (!is_load) begin
      load_result = '0;
    end
  end

  // store data goes to every lane; byte enables pick the real one
  always_comb begin
    case (funct3)
      FUNCT3_BYTE: begin
        st_view.bytes = {4{rs2_data[7:0]}};
        lane_en       = 4'b0001 << addr[1:0];
      end
      FUNCT3_HALF: begin
        st_view.halves = {2{rs2_data[15:0]}};
        lane_en        = addr[1] ? 4'b1100 : 4'b0011; // addr[0] ignored
      end
      default: begin
        st_view.word = rs2_data;
        lane_en      = 4'b1111;
      end
    endcase
  end

  assign store_data = st_view.word;
  assign store_we   = (is_store && !rst) ? lane_en : 4'b0000;

endmodule

//--- source/pc_unit.sv
module pc_unit #(
  parameter rv_pkg::word_t RESET_PC = '0
) (
  input  logic          clk,
  input  logic          rst,
  input  logic          is_branch,
  input  logic          hold,
  input  logic [2:0]    funct3,
  input  rv_pkg::word_t rs1_data,
  input  rv_pkg::word_t rs2_data,
  input  rv_pkg::word_t imm,
  output rv_pkg::word_t pc
);
  import rv_pkg::*;

  logic  taken;
  word_t pc_next;

  // branch condition from funct3
  always_comb begin
    case (funct3)
      3'b000:  taken = (rs1_data == rs2_data);                  // beq
      3'b001:  taken = (rs1_data != rs2_data);                  // bne
      3'b100:  taken = ($signed(rs1_data) < $signed(rs2_data)); // blt
      3'b101:  taken = ($signed(rs1_data) >= $signed(rs2_data));
      3'b110:  taken = (rs1_data < rs2_data);                   // bltu
      3'b111:  taken = (rs1_data >= rs2_data);
      default: taken = 1'b0;
    endcase
  end

  assign pc_next = (is_branch && taken) ? pc + imm : pc + 32'd4;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= RESET_PC;
    end else if (!hold) begin  // halted core stays put
      pc <= pc_next;
    end
  end

endmodule

//--- source/reg_file.sv
module reg_file (
  input  logic             clk,
  input  logic             rst,
  input  logic             we,
  input  rv_pkg::reg_idx_t rd,
  input  rv_pkg::reg_idx_t rs1,
  input  rv_pkg::reg_idx_t rs2,
  input  rv_pkg::word_t    rd_data,
  output rv_pkg::word_t    rs1_data,
  output rv_pkg::word_t    rs2_data
);
  import rv_pkg::*;

  word_t regs [32];

  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != 5'd0) begin  // x0 never written
      regs[rd] <= rd_data;
    end
  end

endmodule

//--- source/rv_core.sv
module rv_core #(
  parameter rv_pkg::word_t RESET_PC = '0
) (
  input  logic          clk,
  input  logic          rst,
  output rv_pkg::word_t pc,
  input  rv_pkg::word_t insn,
  output rv_pkg::word_t dmem_addr,
  input  rv_pkg::word_t load_data,
  output rv_pkg::word_t store_data,
  output logic [3:0]    store_we,
  output logic          halt
);
  import rv_pkg::*;

  reg_idx_t   rs1, rs2, rd;
  word_t      imm;
  alu_op_t    alu_op;
  logic       alu_src_imm, reg_we, is_load, is_store;
  logic       is_branch, is_lui, is_auipc, is_ecall;
  logic [2:0] funct3;
  word_t      rs1_data, rs2_data;
  word_t      alu_b, alu_result, load_result, wb_data;

  insn_decode u_decode (
    .insn(insn), .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm), .alu_op(alu_op),
    .alu_src_imm(alu_src_imm), .reg_we(reg_we), .is_load(is_load),
    .is_store(is_store), .is_branch(is_branch), .is_lui(is_lui),
    .is_auipc(is_auipc), .is_ecall(is_ecall), .funct3(funct3)
  );

  assign halt = is_ecall && !rst;

  reg_file u_regs (
    .clk(clk), .rst(rst), .we(reg_we && !halt), .rd(rd), .rs1(rs1), .rs2(rs2),
    .rd_data(wb_data), .rs1_data(rs1_data), .rs2_data(rs2_data)
  );

  assign alu_b = alu_src_imm ? imm : rs2_data;

  alu u_alu (.op(alu_op), .a(rs1_data), .b(alu_b), .result(alu_result));

  pc_unit #(.RESET_PC(RESET_PC)) u_pc (
    .clk(clk), .rst(rst), .is_branch(is_branch), .hold(halt), .funct3(funct3),
    .rs1_data(rs1_data), .rs2_data(rs2_data), .imm(imm), .pc(pc)
  );

  lsu u_lsu (
    .is_load(is_load), .is_store(is_store), .rst(rst), .funct3(funct3),
    .addr(alu_result), .rs2_data(rs2_data), .load_data(load_data),
    .dmem_addr(dmem_addr), .store_data(store_data), .load_result(load_result),
    .store_we(store_we)
  );

  // write-back source
  always_comb begin
    if (is_lui)        wb_data = imm;
    else if (is_auipc) wb_data = pc + imm;
    else if (is_load)  wb_data = load_result;
    else               wb_data = alu_result;
  end

endmodule

//--- source/rv_pkg.sv
package rv_pkg;

  typedef logic [31:0] word_t;    // register and data word
  typedef logic [4:0]  reg_idx_t; // x0..x31
  typedef logic [6:0]  opcode_t;

  // base opcodes kept by this core
  localparam opcode_t OP_LOAD    = 7'b00_000_11;
  localparam opcode_t OP_STORE   = 7'b01_000_11;
  localparam opcode_t OP_BRANCH  = 7'b11_000_11;
  localparam opcode_t OP_REG_IMM = 7'b00_100_11;
  localparam opcode_t OP_REG_REG = 7'b01_100_11;
  localparam opcode_t OP_LUI     = 7'b01_101_11;
  localparam opcode_t OP_AUIPC   = 7'b00_101_11;
  localparam opcode_t OP_ENVIRON = 7'b11_100_11;

  // memory access widths in funct3
  localparam logic [2:0] FUNCT3_BYTE   = 3'b000;
  localparam logic [2:0] FUNCT3_HALF   = 3'b001;
  localparam logic [2:0] FUNCT3_WORD   = 3'b010;
  localparam logic [2:0] FUNCT3_BYTE_U = 3'b100;
  localparam logic [2:0] FUNCT3_HALF_U = 3'b101;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND
  } alu_op_t;

  // one data word, seen as bytes or as halfwords
  typedef union packed {
    word_t            word;
    logic [3:0][7:0]  bytes;  // lane 0 is the low byte
    logic [1:0][15:0] halves;
  } mem_word_u;

endpackage
